/* Bender.yml */
package:
  name: ldst_unit

sources:
  - hw/ldst_pkg.sv
  - hw/ldst_decode.sv
  - hw/ldst_channel.sv
  - hw/ldst_commit.sv
  - hw/ldst_unit.sv
  - target: simulation
    files:
      - dv/ldst_checker.sv
      - dv/tb_ldst_unit.sv

/* dv/ldst_checker.sv */
// Reference model of the load/store unit that the testbench instantiates beside the DUT to compare its ports every cycle
module ldst_checker
	import ldst_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,
	input	logic			cmd_req,
	input	command_t		command,
	input	issue_no_t		issue_no,
	input	data_t			src_data1,
	input	data_t			src_data2,
	input	data_t			src_data3,
	input	logic			ld_grant,
	input	logic			ld_end,
	input	logic			st_grant,
	input	logic			st_end,
	input	logic			commit_grant,
	input	mem_req_t		ld_mem,
	input	mem_req_t		st_mem,
	input	data_t			st_data,
	input	token_t			wb_token,
	input	data_t			wb_data,
	input	logic			ldst_done,
	input	logic			ld_stall,
	input	logic			st_stall,
	output	int				errors,
	output	int				accepted,
	output	int				writebacks
);

	localparam data_t LD_PATTERN = 32'h5A3C_96E1;		// Memory model load pattern

	chan_in_t	ld_q[$];								// Pushed and not yet finished
	chan_in_t	st_q[$];
	chan_in_t	ld_slot, st_slot, acc_d, wb_exp;
	logic		ld_slot_v, st_slot_v, ld_ended, st_ended, ld_issued, st_issued;
	logic		wb_exp_v, done_exp, fin_ld, fin_st, pick_ld;

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic problem(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	function automatic data_t load_word(input access_t acc);
		return data_t'(acc.base) ^ data_t'(acc.stride) ^ LD_PATTERN;
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			ld_q.delete();
			st_q.delete();
			{ld_slot_v, st_slot_v, ld_ended, st_ended, ld_issued, st_issued} = '0;
			{wb_exp_v, done_exp} = '0;
			acc_d.v = 1'b0;
			errors = 0;
			accepted = 0;
			writebacks = 0;
		end else begin
			////////////////////////////////////////
			// Compare outputs with the model
			////////////////////////////////////////
			compare("ld_stall", ld_q.size() >= 8, ld_stall);
			compare("st_stall", st_q.size() >= 8, st_stall);
			compare("ldst_done", done_exp, ldst_done);
			compare("wb_v", wb_exp_v, wb_token.v);
			if (wb_token.v)
				writebacks++;
			if (wb_exp_v) begin
				compare("wb_token", {wb_exp.token.op, wb_exp.token.dst, wb_exp.token.issue_no},
					{wb_token.op, wb_token.dst, wb_token.issue_no});
				compare("wb_data", wb_exp.token.op.op_class ? data_t'(0) : load_word(wb_exp.access),
					wb_data);
			end
			if (ld_mem.req && ld_q.size() == 0)
				problem("load request raised with no load pending");
			if (st_mem.req && st_q.size() == 0)
				problem("store request raised with no store pending");
			if (ld_grant && ld_q.size() != 0)
				compare("ld_access", ld_q[0].access, ld_mem.access);
			if (st_grant && st_q.size() != 0)
				compare("st_access", st_q[0].access, st_mem.access);
			if (st_issued)
				compare("st_data", st_q[0].st_data, st_data);

			////////////////////////////////////////
			// Advance the model
			////////////////////////////////////////
			fin_ld = ld_issued && (ld_end || ld_ended) && !ld_slot_v;	// Slot must be free
			fin_st = st_issued && (st_end || st_ended) && !st_slot_v;
			wb_exp_v = commit_grant && (ld_slot_v || st_slot_v);
			pick_ld = ld_slot_v && (!st_slot_v || issue_no_t'(issue_no - ld_slot.token.issue_no)
				>= issue_no_t'(issue_no - st_slot.token.issue_no));		// Older goes first
			if (wb_exp_v) begin
				wb_exp = pick_ld ? ld_slot : st_slot;
				if (pick_ld)
					ld_slot_v = 1'b0;
				else
					st_slot_v = 1'b0;
			end
			if (fin_ld) begin
				ld_slot = ld_q.pop_front();
				{ld_slot_v, ld_ended, ld_issued} = 3'b100;
			end else if (ld_end) begin
				ld_ended = 1'b1;
			end
			if (fin_st) begin
				st_slot = st_q.pop_front();
				{st_slot_v, st_ended, st_issued} = 3'b100;
			end else if (st_end) begin
				st_ended = 1'b1;
			end
			if (ld_grant)
				ld_issued = 1'b1;
			if (st_grant)
				st_issued = 1'b1;
			done_exp = fin_ld || fin_st;
			if (acc_d.v && acc_d.token.op.op_class)
				st_q.push_back(acc_d);
			else if (acc_d.v)
				ld_q.push_back(acc_d);
			// Accepted command reaches its queue one cycle later
			acc_d.v = cmd_req && !stall && command.op.op_type == OP_TYPE_MEM;
			acc_d.token = {1'b1, command};
			acc_d.access = {src_data1[WIDTH_ADDR-1:0], src_data1[WIDTH_DATA-1 -: WIDTH_STRIDE],
				src_data2[WIDTH_ADDR-1:0]};
			acc_d.st_data = src_data3;
			if (acc_d.v)
				accepted++;
		end
	end

endmodule

/* dv/tb_ldst_unit.sv */
// Testbench top of the load/store unit, drives random commands against a memory model and checker
module mem_port_model
	import ldst_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	mem_req_t		mem,
	output	logic			ready,
	output	logic			grant,
	output	logic			end_pulse,
	output	data_t			rdata
);

	int			state;
	int			wait_n;
	access_t	acc;

	initial begin
		{ready, grant, end_pulse} = '0;
		rdata = '0;
	end

	always @(posedge clock) begin
		grant <= 1'b0;
		end_pulse <= 1'b0;
		ready <= !reset && ($urandom % 4) != 0;
		if (reset) begin
			state = 0;
		end else if (state == 0 && mem.req) begin
			acc = mem.access;
			wait_n = $urandom % 4;						// Grant delay 0 to 3
			state = 1;
		end else if (state == 1 && wait_n == 0) begin
			ready <= 1'b1;								// Keeps req up for the grant
			grant <= 1'b1;
			wait_n = 1 + $urandom % 4;					// End delay 1 to 4
			state = 2;
		end else if (state == 2 && wait_n <= 1) begin
			end_pulse <= 1'b1;
			rdata <= data_t'(acc.base) ^ data_t'(acc.stride) ^ 32'h5A3C_96E1;
			state = 0;
		end else if (state != 0) begin
			wait_n--;
		end
	end

endmodule

module tb_ldst_unit
	import ldst_pkg::*;
();

	localparam int NUM_CMDS = 300;

	logic clock, reset, stall, cmd_req, commit_grant;
	logic ld_ready, ld_grant, ld_end, st_ready, st_grant, st_end;
	logic ldst_done, ld_stall, st_stall;
	command_t command;
	issue_no_t issue_no;
	data_t src_data1, src_data2, src_data3, ld_data, st_data, wb_data;
	mem_req_t ld_mem, st_mem;
	token_t wb_token;
	int errors, accepted, writebacks;

	ldst_unit i_dut (.*);

	ldst_checker i_checker (.*);

	mem_port_model i_ld_mem (.clock, .reset, .mem(ld_mem), .ready(ld_ready), .grant(ld_grant),
		.end_pulse(ld_end), .rdata(ld_data));

	mem_port_model i_st_mem (.clock, .reset, .mem(st_mem), .ready(st_ready), .grant(st_grant),
		.end_pulse(st_end), .rdata());

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		commit_grant <= !reset && ($urandom % 2);
	end

	initial begin
		repeat (NUM_CMDS * 20) @(posedge clock);
		$display("Timeout: run still busy after %0d cycles", NUM_CMDS * 20);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int sent;
		int gap;
		issue_no_t next_issue;
		void'($urandom(49));
		{reset, stall, cmd_req, commit_grant} = 4'b1000;
		command = '0;
		issue_no = '0;
		{src_data1, src_data2, src_data3} = '0;
		sent = 0;
		gap = 0;
		next_issue = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		while (sent < NUM_CMDS) begin
			@(posedge clock);
			cmd_req <= 1'b0;
			stall <= ($urandom % 8) == 0;
			// Two idle cycles let a push show up in the stall outputs
			if (gap >= 2 && !ld_stall && !st_stall) begin
				next_issue++;
				cmd_req <= 1'b1;
				command.op.op_type <= ($urandom % 4 == 0) ? 2'($urandom) : OP_TYPE_MEM;
				command.op.op_class <= $urandom % 2;
				command.dst <= $urandom;
				command.issue_no <= next_issue;
				issue_no <= next_issue;
				src_data1 <= $urandom;
				src_data2 <= $urandom;
				src_data3 <= $urandom;
				sent++;
				gap = 0;
			end else begin
				gap++;
			end
		end
		@(posedge clock);
		cmd_req <= 1'b0;
		stall <= 1'b0;
		@(negedge clock);
		while (writebacks != accepted)
			@(negedge clock);
		repeat (10) @(negedge clock);
		$display("errors %0d, accepted %0d, writebacks %0d", errors, accepted, writebacks);
		if (errors == 0 && writebacks == accepted) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* hw/ldst_channel.sv */
// Access queue for one direction, issues the head to memory and retires it into the commit slot
module ldst_channel
	import ldst_pkg::*;
#(
	parameter int DEPTH_BUFF_LDST = 8
)(
	input	logic			clock,
	input	logic			reset,
	input	chan_in_t		chan,					// Push from decode
	input	logic			ready,					// Memory can take a request
	input	logic			grant,					// One-cycle grant pulse
	input	logic			end_access,				// One-cycle end pulse
	input	data_t			mem_data,				// Load word at end pulse
	input	logic			slot_full,				// Commit slot still occupied
	output	mem_req_t		mem,
	output	data_t			st_data,
	output	token_t			done_token,
	output	data_t			done_data,
	output	logic			stall					// Queue full
);

	localparam int WIDTH_PTR = (DEPTH_BUFF_LDST > 1) ? $clog2(DEPTH_BUFF_LDST) : 1;
	localparam int WIDTH_CNT = $clog2(DEPTH_BUFF_LDST + 1);

	chan_in_t					buff [DEPTH_BUFF_LDST];
	chan_in_t					head;
	logic [WIDTH_PTR-1:0]		wr_ptr;
	logic [WIDTH_PTR-1:0]		rd_ptr;
	logic [WIDTH_CNT-1:0]		count;
	logic						issued;				// Head granted by memory
	logic						ended;				// Memory ended, slot was full
	data_t						end_data;
	logic						push;
	logic						pop;
	logic						finish;

	assign head		= buff[rd_ptr];
	assign push		= chan.v;
	assign finish	= issued & (end_access | ended) & ~slot_full;
	assign pop		= finish;
	assign stall	= count == WIDTH_CNT'(DEPTH_BUFF_LDST);

	////////////////////////////////////////
	// Queue storage and pointers
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			buff[wr_ptr]	<= chan;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push) begin
				wr_ptr	<= (wr_ptr == WIDTH_PTR'(DEPTH_BUFF_LDST - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr	<= (rd_ptr == WIDTH_PTR'(DEPTH_BUFF_LDST - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	////////////////////////////////////////
	// Access state
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issued	<= 1'b0;
			ended	<= 1'b0;
		end else begin
			if (finish) begin
				issued	<= 1'b0;
			end else if (grant) begin
				issued	<= 1'b1;
			end
			if (finish) begin
				ended	<= 1'b0;
			end else if (end_access && issued) begin
				ended	<= 1'b1;					// Wait for the slot to drain
			end
		end
	end

	always_ff @(posedge clock) begin
		if (end_access) begin
			end_data	<= mem_data;
		end
	end

	always_comb begin
		mem.req		= (count != '0) & ~issued & ready;
		mem.access	= head.access;
	end

	assign st_data		= issued ? head.st_data : '0;	// Store word while in flight
	assign done_data	= ended ? end_data : mem_data;

	always_comb begin
		done_token		= head.token;
		done_token.v	= finish;
	end

	assert property (@(posedge clock) disable iff (reset) !(chan.v && stall));

	assert property (@(posedge clock) disable iff (reset) grant |-> mem.req);

	// One access in flight, and the memory ends it only once
	assert property (@(posedge clock) disable iff (reset) end_access |-> issued && !ended);

endmodule

/* hw/ldst_commit.sv */
// Commit stage that holds one finished token per direction and writes back the older one on a grant
module ldst_commit
	import ldst_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	issue_no_t		issue_no,				// Current issue number
	input	token_t			ld_done_token,
	input	token_t			st_done_token,
	input	data_t			ld_done_data,
	input	logic			commit_grant,
	output	logic			ld_slot_full,
	output	logic			st_slot_full,
	output	token_t			wb_token,
	output	data_t			wb_data,
	output	logic			ldst_done				// Access finished
);

	token_t			ld_slot;
	token_t			st_slot;
	data_t			ld_slot_data;
	issue_no_t		age_ld;
	issue_no_t		age_st;
	logic			pick_ld;
	logic			release_ld;
	logic			release_st;
	token_t			wb_q;
	logic			wb_v;

	assign ld_slot_full	= ld_slot.v;
	assign st_slot_full	= st_slot.v;

	assign age_ld		= issue_no - ld_slot.issue_no;		// Modular age
	assign age_st		= issue_no - st_slot.issue_no;
	assign pick_ld		= ld_slot.v & (~st_slot.v | (age_ld >= age_st));
	assign release_ld	= commit_grant & pick_ld;
	assign release_st	= commit_grant & st_slot.v & ~pick_ld;

	////////////////////////////////////////
	// Slots and writeback
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_slot.v	<= 1'b0;
			st_slot.v	<= 1'b0;
			wb_v		<= 1'b0;
			ldst_done	<= 1'b0;
		end else begin
			if (ld_done_token.v) begin
				ld_slot.v	<= 1'b1;
			end else if (release_ld) begin
				ld_slot.v	<= 1'b0;
			end
			if (st_done_token.v) begin
				st_slot.v	<= 1'b1;
			end else if (release_st) begin
				st_slot.v	<= 1'b0;
			end
			wb_v		<= release_ld | release_st;
			ldst_done	<= ld_done_token.v | st_done_token.v;
		end
	end

	always_ff @(posedge clock) begin
		if (ld_done_token.v) begin
			ld_slot.op			<= ld_done_token.op;
			ld_slot.dst			<= ld_done_token.dst;
			ld_slot.issue_no	<= ld_done_token.issue_no;
			ld_slot_data		<= ld_done_data;
		end
		if (st_done_token.v) begin
			st_slot.op			<= st_done_token.op;
			st_slot.dst			<= st_done_token.dst;
			st_slot.issue_no	<= st_done_token.issue_no;
		end
		wb_q	<= pick_ld ? ld_slot : st_slot;
		wb_data	<= pick_ld ? ld_slot_data : '0;	// Stores write back zero
	end

	always_comb begin
		wb_token	= wb_q;
		wb_token.v	= wb_v;
	end

	// Channels hold their finished access until the slot drains
	assert property (@(posedge clock) disable iff (reset)
		(ld_done_token.v |-> !ld_slot.v) and (st_done_token.v |-> !st_slot.v));

endmodule

/* hw/ldst_decode.sv */
// Decode stage of the load/store unit that registers each issued command into the load or store channel
module ldst_decode
	import ldst_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,					// Freezes decode
	input	logic			cmd_req,				// Command valid this cycle
	input	command_t		command,
	input	issue_no_t		issue_no,				// Current issue number
	input	data_t			src_data1,				// Descriptor
	input	data_t			src_data2,				// Base
	input	data_t			src_data3,				// Store data
	output	chan_in_t		ld_in,
	output	chan_in_t		st_in
);

	desc_word_u		desc_word;
	chan_in_t		chan_next;
	chan_in_t		chan_q;
	issue_no_t		cmd_age;
	logic			is_mem;
	logic			accept;
	logic			ld_v;
	logic			st_v;

	assign desc_word.data	= src_data1;
	assign is_mem			= command.op.op_type == OP_TYPE_MEM;
	assign accept			= cmd_req & ~stall & is_mem;		// Other op types dropped
	assign cmd_age			= issue_no - command.issue_no;

	always_comb begin
		chan_next.v					= accept;
		chan_next.token.v			= accept;
		chan_next.token.op			= command.op;
		chan_next.token.dst			= command.dst;
		chan_next.token.issue_no	= command.issue_no;
		chan_next.access.length		= desc_word.desc.length;
		chan_next.access.stride		= desc_word.desc.stride;
		chan_next.access.base		= src_data2[WIDTH_ADDR-1:0];
		chan_next.st_data			= src_data3;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_v	<= 1'b0;
			st_v	<= 1'b0;
		end else begin
			ld_v	<= accept & (command.op.op_class == OP_CLASS_LOAD);
			st_v	<= accept & (command.op.op_class == OP_CLASS_STORE);
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			chan_q	<= chan_next;						// Payload only
		end
	end

	// Both channels see the same payload and differ only in the valid
	always_comb begin
		ld_in			= chan_q;
		ld_in.v			= ld_v;
		ld_in.token.v	= ld_v;
		st_in			= chan_q;
		st_in.v			= st_v;
		st_in.token.v	= st_v;
	end

	// Commit compares ages against the current issue number, so accepted
	// commands must not run ahead of it by more than half the wrap range
	assert property (@(posedge clock) disable iff (reset)
		accept |-> !cmd_age[WIDTH_ISSUE-1]);

endmodule

/* hw/ldst_pkg.sv */
// Shared widths, encodings and structs of the load/store unit, imported by every RTL module
package ldst_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int WIDTH_DATA		= 32;						// Data word
	localparam int WIDTH_ADDR		= 12;						// Address and length
	localparam int WIDTH_STRIDE		= 8;						// Stride, top of descriptor
	localparam int WIDTH_ISSUE		= 6;						// Issue number, wraps
	localparam int WIDTH_DST		= 5;						// Destination register index
	localparam int WIDTH_DESC_PAD	= WIDTH_DATA - WIDTH_STRIDE - WIDTH_ADDR;

	////////////////////////////////////////
	// Opcode fields
	////////////////////////////////////////

	localparam logic [1:0] OP_TYPE_MEM	= 2'b11;				// Memory access
	localparam logic OP_CLASS_LOAD		= 1'b0;
	localparam logic OP_CLASS_STORE		= 1'b1;

	typedef logic [WIDTH_DATA-1:0]		data_t;
	typedef logic [WIDTH_ADDR-1:0]		address_t;
	typedef logic [WIDTH_STRIDE-1:0]	stride_t;
	typedef logic [WIDTH_ISSUE-1:0]		issue_no_t;

	typedef struct packed {
		logic [1:0]				op_type;						// 3 selects memory access
		logic					op_class;						// 0 load, 1 store
	} op_t;

	typedef struct packed {
		op_t					op;
		logic [WIDTH_DST-1:0]	dst;
		issue_no_t				issue_no;
	} command_t;

	// Source word 1 is either plain data or a strided access descriptor
	typedef union packed {
		data_t					data;
		struct packed {
			stride_t						stride;				// Top bits
			logic [WIDTH_DESC_PAD-1:0]		pad;
			address_t						length;				// Low bits
		} desc;
	} desc_word_u;

	////////////////////////////////////////
	// Pipeline records
	////////////////////////////////////////

	typedef struct packed {
		address_t				length;
		stride_t				stride;
		address_t				base;
	} access_t;

	typedef struct packed {
		logic					v;
		op_t					op;
		logic [WIDTH_DST-1:0]	dst;
		issue_no_t				issue_no;
	} token_t;

	typedef struct packed {
		logic					v;
		token_t					token;
		access_t				access;
		data_t					st_data;						// Store word, unused by loads
	} chan_in_t;

	typedef struct packed {
		logic					req;							// Level while head is unissued
		access_t				access;
	} mem_req_t;

endpackage

/* hw/ldst_unit.sv */
// Top level of the load/store unit, connects decode, the load and store channels and commit
module ldst_unit
	import ldst_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,					// Pipeline stall
	input	logic			cmd_req,
	input	command_t		command,
	input	issue_no_t		issue_no,
	input	data_t			src_data1,				// Descriptor
	input	data_t			src_data2,				// Base
	input	data_t			src_data3,				// Store data
	input	logic			ld_ready,
	input	logic			ld_grant,
	input	logic			ld_end,
	input	data_t			ld_data,
	input	logic			st_ready,
	input	logic			st_grant,
	input	logic			st_end,
	input	logic			commit_grant,
	output	mem_req_t		ld_mem,
	output	mem_req_t		st_mem,
	output	data_t			st_data,
	output	token_t			wb_token,
	output	data_t			wb_data,
	output	logic			ldst_done,
	output	logic			ld_stall,
	output	logic			st_stall
);

	chan_in_t		ld_in;
	chan_in_t		st_in;
	token_t			ld_done_token;
	token_t			st_done_token;
	data_t			ld_done_data;
	logic			ld_slot_full;
	logic			st_slot_full;

	ldst_decode i_decode (
		.clock		(clock),
		.reset		(reset),
		.stall		(stall),
		.cmd_req	(cmd_req),
		.command	(command),
		.issue_no	(issue_no),
		.src_data1	(src_data1),
		.src_data2	(src_data2),
		.src_data3	(src_data3),
		.ld_in		(ld_in),
		.st_in		(st_in)
	);

	ldst_channel ld_channel (
		.clock		(clock),
		.reset		(reset),
		.chan		(ld_in),
		.ready		(ld_ready),
		.grant		(ld_grant),
		.end_access	(ld_end),
		.mem_data	(ld_data),
		.slot_full	(ld_slot_full),
		.mem		(ld_mem),
		.st_data	(),							// Loads carry no store word
		.done_token	(ld_done_token),
		.done_data	(ld_done_data),
		.stall		(ld_stall)
	);

	ldst_channel st_channel (
		.clock		(clock),
		.reset		(reset),
		.chan		(st_in),
		.ready		(st_ready),
		.grant		(st_grant),
		.end_access	(st_end),
		.mem_data	('0),						// Stores return nothing
		.slot_full	(st_slot_full),
		.mem		(st_mem),
		.st_data	(st_data),
		.done_token	(st_done_token),
		.done_data	(),
		.stall		(st_stall)
	);

	ldst_commit i_commit (
		.clock			(clock),
		.reset			(reset),
		.issue_no		(issue_no),
		.ld_done_token	(ld_done_token),
		.st_done_token	(st_done_token),
		.ld_done_data	(ld_done_data),
		.commit_grant	(commit_grant),
		.ld_slot_full	(ld_slot_full),
		.st_slot_full	(st_slot_full),
		.wb_token		(wb_token),
		.wb_data		(wb_data),
		.ldst_done		(ldst_done)
	);

endmodule

/* ldst_unit.f */
hw/ldst_pkg.sv
hw/ldst_decode.sv
hw/ldst_channel.sv
hw/ldst_commit.sv
hw/ldst_unit.sv
dv/ldst_checker.sv
dv/tb_ldst_unit.sv
